// ==== hw/rv_isa_pkg.sv ====
/*
  RV32I instruction-set definitions: word, register index and opcode types,
  base opcodes, branch and ALU funct3 codes, reset address
*/
package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;

  // base opcode map, bits [6:0]
  localparam opcode_t OPCODE_LOAD     = 7'b0000011;
  localparam opcode_t OPCODE_MISC_MEM = 7'b0001111;
  localparam opcode_t OPCODE_OP_IMM   = 7'b0010011;
  localparam opcode_t OPCODE_AUIPC    = 7'b0010111;
  localparam opcode_t OPCODE_STORE    = 7'b0100011;
  localparam opcode_t OPCODE_OP       = 7'b0110011;
  localparam opcode_t OPCODE_LUI      = 7'b0110111;
  localparam opcode_t OPCODE_BRANCH   = 7'b1100011;
  localparam opcode_t OPCODE_JALR     = 7'b1100111;
  localparam opcode_t OPCODE_JAL      = 7'b1101111;

  // branch conditions
  localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
  localparam logic [2:0] FUNCT3_BNE  = 3'b001;
  localparam logic [2:0] FUNCT3_BLT  = 3'b100;
  localparam logic [2:0] FUNCT3_BGE  = 3'b101;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;
  localparam logic [2:0] FUNCT3_BGEU = 3'b111;

  // alu functions, shared by OP and OP-IMM
  localparam logic [2:0] FUNCT3_ALU_ADD_SUB = 3'b000;
  localparam logic [2:0] FUNCT3_ALU_SLL     = 3'b001;
  localparam logic [2:0] FUNCT3_ALU_SLT     = 3'b010;
  localparam logic [2:0] FUNCT3_ALU_SLTU    = 3'b011;
  localparam logic [2:0] FUNCT3_ALU_XOR     = 3'b100;
  localparam logic [2:0] FUNCT3_ALU_SHIFTR  = 3'b101;
  localparam logic [2:0] FUNCT3_ALU_OR      = 3'b110;
  localparam logic [2:0] FUNCT3_ALU_AND     = 3'b111;

  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

// ==== hw/rv_ctl_pkg.sv ====
/*
  decoder to datapath control encodings: ALU operation class,
  next-PC, writeback and ALU operand selects
*/
package rv_ctl_pkg;

  // how the ALU picks its function
  typedef enum logic [1:0] {
    CTL_ALU_ADD    = 2'd0,
    CTL_ALU_OP_IMM = 2'd1,
    CTL_ALU_OP     = 2'd2,
    CTL_ALU_BRANCH = 2'd3
  } alu_op_t;

  typedef enum logic [1:0] {
    CTL_PC_PC4     = 2'd0,
    CTL_PC_PC_IMM  = 2'd1,
    CTL_PC_RS1_IMM = 2'd2
  } next_pc_sel_t;

  typedef enum logic [2:0] {
    CTL_WRITEBACK_ALU  = 3'd0,
    CTL_WRITEBACK_DATA = 3'd1,
    CTL_WRITEBACK_IMM  = 3'd2,
    CTL_WRITEBACK_PC4  = 3'd3
  } writeback_sel_t;

  typedef enum logic {CTL_ALU_A_RS1 = 1'b0, CTL_ALU_A_PC  = 1'b1} alu_a_sel_t;
  typedef enum logic {CTL_ALU_B_RS2 = 1'b0, CTL_ALU_B_IMM = 1'b1} alu_b_sel_t;

endpackage

// ==== hw/ctl_if.sv ====
/*
  control bundle between main decoder and datapath,
  decoder and datapath modports
*/
interface ctl_if (
  input logic clock,
  input logic rst_n
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  alu_op_t        alu_op_type;
  logic           data_mem_read_enable;
  logic           data_mem_write_enable;
  writeback_sel_t reg_writeback_select;
  next_pc_sel_t   next_pc_select;
  logic           regfile_write_enable;
  alu_a_sel_t     alu_operand_a_select;
  alu_b_sel_t     alu_operand_b_select;

  // fed back from the datapath
  opcode_t        inst_opcode;
  logic           take_branch;

  modport decoder (
    input  clock, rst_n, inst_opcode, take_branch,
    output alu_op_type, data_mem_read_enable, data_mem_write_enable,
    output reg_writeback_select, next_pc_select, regfile_write_enable,
    output alu_operand_a_select, alu_operand_b_select
  );

  modport datapath (
    input  alu_op_type, data_mem_read_enable, data_mem_write_enable,
    input  reg_writeback_select, next_pc_select, regfile_write_enable,
    input  alu_operand_a_select, alu_operand_b_select,
    output inst_opcode, take_branch
  );

endinterface

// ==== hw/singlecycle_control.sv ====
/*
  main decoder: opcode and branch outcome to datapath selects
*/
module singlecycle_control (
  ctl_if.decoder ctl
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  always_comb
  begin
    case (ctl.inst_opcode)
      OPCODE_BRANCH: ctl.next_pc_select = ctl.take_branch ? CTL_PC_PC_IMM : CTL_PC_PC4;
      OPCODE_JALR:   ctl.next_pc_select = CTL_PC_RS1_IMM;
      OPCODE_JAL:    ctl.next_pc_select = CTL_PC_PC_IMM;
      default:       ctl.next_pc_select = CTL_PC_PC4;
    endcase
  end

  always_comb
  begin
    // defaults cover FENCE and unknown opcodes, nothing is written
    ctl.alu_op_type           = CTL_ALU_ADD;
    ctl.data_mem_read_enable  = 1'b0;
    ctl.data_mem_write_enable = 1'b0;
    ctl.regfile_write_enable  = 1'b0;
    ctl.reg_writeback_select  = CTL_WRITEBACK_ALU;
    ctl.alu_operand_a_select  = CTL_ALU_A_RS1;
    ctl.alu_operand_b_select  = CTL_ALU_B_RS2;

    case (ctl.inst_opcode)
      OPCODE_LOAD:
      begin
        ctl.data_mem_read_enable = 1'b1;
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = CTL_WRITEBACK_DATA;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
      end
      OPCODE_STORE:
      begin
        ctl.data_mem_write_enable = 1'b1;
        ctl.alu_operand_b_select  = CTL_ALU_B_IMM;
      end
      OPCODE_OP_IMM:
      begin
        ctl.alu_op_type          = CTL_ALU_OP_IMM;
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
      end
      OPCODE_OP:
      begin
        ctl.alu_op_type          = CTL_ALU_OP;
        ctl.regfile_write_enable = 1'b1;
      end
      OPCODE_AUIPC:
      begin
        ctl.regfile_write_enable = 1'b1;
        ctl.alu_operand_a_select = CTL_ALU_A_PC;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
      end
      OPCODE_LUI:
      begin
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = CTL_WRITEBACK_IMM;
      end
      OPCODE_BRANCH:
      begin
        ctl.alu_op_type = CTL_ALU_BRANCH;
      end
      OPCODE_JALR, OPCODE_JAL:
      begin
        // link value is pc+4, target comes from the next-pc mux
        ctl.regfile_write_enable = 1'b1;
        ctl.reg_writeback_select = CTL_WRITEBACK_PC4;
        ctl.alu_operand_b_select = CTL_ALU_B_IMM;
        if (ctl.inst_opcode == OPCODE_JAL)
          ctl.alu_operand_a_select = CTL_ALU_A_PC;
      end
      default:
      begin
      end
    endcase
  end

  // a data access is a load or a store, never both in one cycle
  a_mem_excl: assert property (@(posedge ctl.clock) disable iff (!ctl.rst_n)
    !(ctl.data_mem_read_enable && ctl.data_mem_write_enable));

endmodule

// ==== hw/imm_decoder.sv ====
/*
  immediate generator for the I, S, B, U and J formats
*/
module imm_decoder (
  input  rv_isa_pkg::word_t inst,
  output rv_isa_pkg::word_t imm
);
  import rv_isa_pkg::*;

  opcode_t opcode;

  assign opcode = inst[6:0];

  always_comb
  begin
    case (opcode)
      OPCODE_STORE:
        imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      OPCODE_BRANCH:
        imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      OPCODE_LUI, OPCODE_AUIPC:
        imm = {inst[31:12], 12'b0};
      OPCODE_JAL:
        imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      // I-type: loads, op-imm, jalr
      default:
        imm = {{20{inst[31]}}, inst[31:20]};
    endcase
  end

endmodule

// ==== hw/regfile.sv ====
/*
  32 x 32-bit integer register file, two read ports, one write port
*/
module regfile (
  input  logic                  clock,
  input  logic                  rst_n,
  input  rv_isa_pkg::reg_addr_t rs1_addr,
  input  rv_isa_pkg::reg_addr_t rs2_addr,
  input  rv_isa_pkg::reg_addr_t rd_addr,
  input  rv_isa_pkg::word_t     rd_data,
  input  logic                  write_enable,
  output rv_isa_pkg::word_t     rs1_data,
  output rv_isa_pkg::word_t     rs2_data
);
  import rv_isa_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 32; i++)
        regs[i] <= '0;
    end
    else if (write_enable && (rd_addr != '0))
      regs[rd_addr] <= rd_data;
  end

  // x0 is hardwired to zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/rv_alu.sv ====
/*
  integer ALU with function decode and branch comparator
*/
module rv_alu (
  input  rv_ctl_pkg::alu_op_t alu_op_type,
  input  logic [2:0]          funct3,
  input  logic                funct7_bit5,
  input  logic                is_op_imm,
  input  rv_isa_pkg::word_t   a,
  input  rv_isa_pkg::word_t   b,
  output rv_isa_pkg::word_t   result,
  output logic                take_branch
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  logic [4:0] shamt;
  logic       sub_sel;
  word_t      sra_result;

  assign shamt = b[4:0];
  // bit 30 of an immediate is data, except for srai
  assign sub_sel    = funct7_bit5 && !is_op_imm;
  assign sra_result = $signed(a) >>> shamt;

  always_comb
  begin
    result      = a + b;
    take_branch = 1'b0;
    case (alu_op_type)
      CTL_ALU_OP, CTL_ALU_OP_IMM:
      begin
        case (funct3)
          FUNCT3_ALU_ADD_SUB: result = sub_sel ? (a - b) : (a + b);
          FUNCT3_ALU_SLL:     result = a << shamt;
          FUNCT3_ALU_SLT:     result = {31'b0, $signed(a) < $signed(b)};
          FUNCT3_ALU_SLTU:    result = {31'b0, a < b};
          FUNCT3_ALU_XOR:     result = a ^ b;
          FUNCT3_ALU_SHIFTR:  result = funct7_bit5 ? sra_result : (a >> shamt);
          FUNCT3_ALU_OR:      result = a | b;
          FUNCT3_ALU_AND:     result = a & b;
        endcase
      end
      CTL_ALU_BRANCH:
      begin
        case (funct3)
          FUNCT3_BEQ:  take_branch = (a == b);
          FUNCT3_BNE:  take_branch = (a != b);
          FUNCT3_BLT:  take_branch = ($signed(a) < $signed(b));
          FUNCT3_BGE:  take_branch = ($signed(a) >= $signed(b));
          FUNCT3_BLTU: take_branch = (a < b);
          FUNCT3_BGEU: take_branch = (a >= b);
          default:     take_branch = 1'b0;
        endcase
      end
      default:
      begin
      end
    endcase
  end

endmodule

// ==== hw/singlecycle_datapath.sv ====
/*
  single-cycle datapath: pc and start flag, operand and writeback muxes,
  next-pc logic, instruction and data memory ports
*/
module singlecycle_datapath (
  input  logic              clock,
  input  logic              rst_n,
  ctl_if.datapath           ctl,
  output rv_isa_pkg::word_t imem_addr,
  input  rv_isa_pkg::word_t imem_data,
  output rv_isa_pkg::word_t dmem_addr,
  output rv_isa_pkg::word_t dmem_wdata,
  output logic              dmem_read_enable,
  output logic              dmem_write_enable,
  input  rv_isa_pkg::word_t dmem_rdata
);
  import rv_isa_pkg::*;
  import rv_ctl_pkg::*;

  word_t pc;
  word_t pc_plus4;
  word_t next_pc;
  word_t imm;
  word_t rs1_data;
  word_t rs2_data;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t wb_data;
  logic  started;

  // pc holds at RESET_PC until the first cycle after reset has passed
  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      started <= 1'b0;
      pc      <= RESET_PC;
    end
    else
    begin
      started <= 1'b1;
      if (started)
        pc <= next_pc;
    end
  end

  assign imem_addr       = pc;
  assign pc_plus4        = pc + 32'd4;
  assign ctl.inst_opcode = imem_data[6:0];

  imm_decoder imm_inst (.inst(imem_data), .imm(imm));

  regfile regfile_inst (
    .clock(clock), .rst_n(rst_n),
    .rs1_addr(imem_data[19:15]), .rs2_addr(imem_data[24:20]), .rd_addr(imem_data[11:7]),
    .rd_data(wb_data), .write_enable(ctl.regfile_write_enable && started),
    .rs1_data(rs1_data), .rs2_data(rs2_data)
  );

  assign alu_a = (ctl.alu_operand_a_select == CTL_ALU_A_PC) ? pc : rs1_data;
  assign alu_b = (ctl.alu_operand_b_select == CTL_ALU_B_IMM) ? imm : rs2_data;

  rv_alu alu_inst (
    .alu_op_type(ctl.alu_op_type), .funct3(imem_data[14:12]), .funct7_bit5(imem_data[30]),
    .is_op_imm(imem_data[6:0] == OPCODE_OP_IMM), .a(alu_a), .b(alu_b),
    .result(alu_result), .take_branch(ctl.take_branch)
  );

  always_comb
  begin
    case (ctl.reg_writeback_select)
      CTL_WRITEBACK_DATA: wb_data = dmem_rdata;
      CTL_WRITEBACK_IMM:  wb_data = imm;
      CTL_WRITEBACK_PC4:  wb_data = pc_plus4;
      default:            wb_data = alu_result;
    endcase
  end

  // jalr target is rs1+imm from the alu, low bit cleared
  always_comb
  begin
    case (ctl.next_pc_select)
      CTL_PC_PC_IMM:  next_pc = pc + imm;
      CTL_PC_RS1_IMM: next_pc = {alu_result[31:1], 1'b0};
      default:        next_pc = pc_plus4;
    endcase
  end

  assign dmem_addr         = alu_result;
  assign dmem_wdata        = rs2_data;
  assign dmem_read_enable  = ctl.data_mem_read_enable && started;
  assign dmem_write_enable = ctl.data_mem_write_enable && started;

  a_pc_aligned: assert property (@(posedge clock) disable iff (!rst_n) pc[1:0] == 2'b00);

endmodule

// ==== hw/rv_core.sv ====
/*
  RV32I single-cycle core top level
  instruction port and data port
*/
module rv_core (
  input  logic              clock,
  input  logic              rst_n,
  output rv_isa_pkg::word_t imem_addr,
  input  rv_isa_pkg::word_t imem_data,
  output rv_isa_pkg::word_t dmem_addr,
  output rv_isa_pkg::word_t dmem_wdata,
  output logic              dmem_read_enable,
  output logic              dmem_write_enable,
  input  rv_isa_pkg::word_t dmem_rdata
);

  ctl_if ctl (
    .clock(clock),
    .rst_n(rst_n)
  );

  singlecycle_control control_inst (
    .ctl(ctl.decoder)
  );

  singlecycle_datapath datapath_inst (
    .clock(clock),
    .rst_n(rst_n),
    .ctl(ctl.datapath),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_read_enable(dmem_read_enable),
    .dmem_write_enable(dmem_write_enable),
    .dmem_rdata(dmem_rdata)
  );

endmodule

// ==== tests/tb_clock.sv ====
/*
  testbench clock and reset source
*/
module tb_clock (
  output logic clock,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int HALF_PERIOD  = 50;
  localparam int RESET_CYCLES = 5;

  initial
  begin
    clock = 1'b0;
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    // release away from the rising edge
    @(negedge clock);
    rst_n = 1'b1;
  end

  always #HALF_PERIOD clock = ~clock;

endmodule

// ==== tests/tb_core.sv ====
/*
  testbench for the single-cycle core: instruction and data memory models,
  program loading from the data file, store and read enable checks, timeout
*/
module tb_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_isa_pkg::*;

  localparam int MAX_CYCLES  = 2000;
  localparam int MAX_RECORDS = 128;
  localparam int MEM_WORDS   = 256;
  localparam word_t END_ADDR = 32'h0000_0ffc;
  // sw x0, 256(x0)
  localparam word_t HOLD_INST = 32'h1000_2023;

  logic  clock;
  logic  rst_n;
  word_t imem_addr;
  word_t imem_data;
  word_t dmem_addr;
  word_t dmem_wdata;
  word_t dmem_rdata;
  logic  dmem_read_enable;
  logic  dmem_write_enable;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  // three words per record: kind, address, value
  word_t records [3 * MAX_RECORDS];
  word_t exp_addr [$];
  word_t exp_data [$];
  int    store_count = 0;
  logic  end_seen = 1'b0;
  logic  fetch_live = 1'b0;

  tb_clock clock_inst (
    .clock(clock),
    .rst_n(rst_n)
  );

  rv_core rv_core_inst (
    .clock(clock),
    .rst_n(rst_n),
    .imem_addr(imem_addr),
    .imem_data(imem_data),
    .dmem_addr(dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_read_enable(dmem_read_enable),
    .dmem_write_enable(dmem_write_enable),
    .dmem_rdata(dmem_rdata)
  );

  // first instruction executes in the cycle after this goes high
  always @(posedge clock)
  begin
    if (rst_n)
      fetch_live <= 1'b1;
  end

  // until then the bus offers a store the core must not perform
  assign imem_data  = fetch_live ? imem[imem_addr[9:2]] : HOLD_INST;
  assign dmem_rdata = dmem[dmem_addr[9:2]];

  always @(posedge clock)
  begin
    if (dmem_write_enable)
      dmem[dmem_addr[9:2]] <= dmem_wdata;
  end

  task automatic stop_with_failure();
    $display(">>> FAIL");
    $fatal(1, "test stopped at the first error");
  endtask

  task automatic check_equal(string what, word_t actual, word_t expected);
    if (actual !== expected)
    begin
      $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
      stop_with_failure();
    end
  endtask

  task automatic load_tests();
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      // nop fill, addi x0, x0, index
      imem[i] = (word_t'(i) << 20) | 32'h0000_0013;
      dmem[i] = 32'h5a5a_0000 + word_t'(i);
    end
    for (int i = 0; i < 3 * MAX_RECORDS; i++)
      records[i] = '0;
    $readmemh("tests/core_tests.txt", records);
    for (int i = 0; i < MAX_RECORDS; i++)
    begin
      if (records[3 * i] == 32'd1)
        imem[records[3 * i + 1][9:2]] = records[3 * i + 2];
      else if (records[3 * i] == 32'd2)
      begin
        exp_addr.push_back(records[3 * i + 1]);
        exp_data.push_back(records[3 * i + 2]);
      end
    end
  endtask

  // every store is compared in program order
  always @(posedge clock)
  begin
    // only a load reads data memory
    check_equal("data read enable", word_t'(dmem_read_enable),
                word_t'(fetch_live && imem_data[6:0] == OPCODE_LOAD));
    check_equal("fetch address low bits", word_t'(imem_addr[1:0]), '0);
    if (dmem_write_enable)
    begin
      if (!fetch_live)
      begin
        $display("a data write appeared before the first instruction executed");
        stop_with_failure();
      end
      else if (store_count >= exp_addr.size())
      begin
        $display("a store to %h came after the last expected store", dmem_addr);
        stop_with_failure();
      end
      else
      begin
        check_equal("store address", dmem_addr, exp_addr[store_count]);
        check_equal("store data", dmem_wdata, exp_data[store_count]);
        store_count++;
        if (dmem_addr == END_ADDR)
          end_seen = 1'b1;
      end
    end
  end

  initial
  begin
    int cycles;

    load_tests();
    if (exp_addr.size() == 0)
    begin
      $display("the data file holds no expected stores");
      stop_with_failure();
    end

    cycles = 0;
    while (!rst_n && cycles < 20)
    begin
      @(negedge clock);
      cycles++;
    end
    if (!rst_n)
    begin
      $display("reset was never released");
      stop_with_failure();
    end
    check_equal("first fetch address", imem_addr, RESET_PC);

    // run until the store to the end address
    cycles = 0;
    while (!end_seen && cycles < MAX_CYCLES)
    begin
      @(negedge clock);
      cycles++;
    end

    if (!end_seen)
    begin
      $display("timeout: no store to the end address within %0d cycles", MAX_CYCLES);
      stop_with_failure();
    end
    else if (store_count != exp_addr.size())
    begin
      $display("only %0d of %0d expected stores were seen", store_count, exp_addr.size());
      stop_with_failure();
    end
    else
    begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== tests/core_tests.txt ====
// columns: kind address value, all hex
// kind 1 is a program word, kind 2 an expected store in program order
1 00000000 00500093 // addi x1, x0, 5
1 00000004 FFD00113 // addi x2, x0, -3
1 00000008 002081B3 // add x3, x1, x2
1 0000000C 00302023 // sw x3, 0(x0)
1 00000010 40208233 // sub x4, x1, x2
1 00000014 00402223 // sw x4, 4(x0)
1 00000018 0020F2B3 // and x5, x1, x2
1 0000001C 0020E333 // or x6, x1, x2
1 00000020 0020C3B3 // xor x7, x1, x2
1 00000024 00502423 // sw x5, 8(x0)
1 00000028 00602623 // sw x6, 12(x0)
1 0000002C 00702823 // sw x7, 16(x0)
1 00000030 00112433 // slt x8, x2, x1
1 00000034 001134B3 // sltu x9, x2, x1
1 00000038 00109533 // sll x10, x1, x1
1 0000003C 001155B3 // srl x11, x2, x1
1 00000040 40115633 // sra x12, x2, x1
1 00000044 00802A23 // sw x8, 20(x0)
1 00000048 00902C23 // sw x9, 24(x0)
1 0000004C 00A02E23 // sw x10, 28(x0)
1 00000050 02B02023 // sw x11, 32(x0)
1 00000054 02C02223 // sw x12, 36(x0)
1 00000058 00411693 // slli x13, x2, 4
1 0000005C 40115713 // srai x14, x2, 1
1 00000060 01C15793 // srli x15, x2, 28
1 00000064 02D02423 // sw x13, 40(x0)
1 00000068 02E02623 // sw x14, 44(x0)
1 0000006C 02F02823 // sw x15, 48(x0)
1 00000070 00402803 // lw x16, 4(x0)
1 00000074 00180013 // addi x0, x16, 1
1 00000078 000808B3 // add x17, x16, x0
1 0000007C 03102A23 // sw x17, 52(x0)
1 00000080 00001FB7 // lui x31, 1
1 00000084 FFCF8F93 // addi x31, x31, -4
1 00000088 00002917 // auipc x18, 2
1 0000008C 03202C23 // sw x18, 56(x0)
1 00000090 03F02E23 // sw x31, 60(x0)
1 00000094 00208463 // beq x1, x2, +8 not taken
1 00000098 00108463 // beq x1, x1, +8 taken
1 0000009C 10002023 // sw x0, 256(x0) skipped
1 000000A0 00109463 // bne x1, x1, +8 not taken
1 000000A4 00209463 // bne x1, x2, +8 taken
1 000000A8 10002023 // skipped
1 000000AC 0020C463 // blt x1, x2, +8 not taken
1 000000B0 00114463 // blt x2, x1, +8 taken
1 000000B4 10002023 // skipped
1 000000B8 00115463 // bge x2, x1, +8 not taken
1 000000BC 0020D463 // bge x1, x2, +8 taken
1 000000C0 10002023 // skipped
1 000000C4 00116463 // bltu x2, x1, +8 not taken
1 000000C8 0020E463 // bltu x1, x2, +8 taken
1 000000CC 10002023 // skipped
1 000000D0 0020F463 // bgeu x1, x2, +8 not taken
1 000000D4 00117463 // bgeu x2, x1, +8 taken
1 000000D8 10002023 // skipped
1 000000DC 008009EF // jal x19, +8
1 000000E0 10002023 // skipped
1 000000E4 0F100A93 // addi x21, x0, 0xf1
1 000000E8 000A8A67 // jalr x20, 0(x21), lands on 0xf0
1 000000EC 10002023 // skipped
1 000000F0 05302023 // sw x19, 64(x0)
1 000000F4 05402223 // sw x20, 68(x0)
1 000000F8 001FA023 // sw x1, 0(x31), end of test
1 000000FC 0000006F // jal x0, 0
2 00000000 00000002 // add
2 00000004 00000008 // sub
2 00000008 00000005 // and
2 0000000C FFFFFFFD // or
2 00000010 FFFFFFF8 // xor
2 00000014 00000001 // slt
2 00000018 00000000 // sltu
2 0000001C 000000A0 // sll
2 00000020 07FFFFFF // srl
2 00000024 FFFFFFFF // sra
2 00000028 FFFFFFD0 // slli
2 0000002C FFFFFFFE // srai
2 00000030 0000000F // srli
2 00000034 00000008 // lw through x0
2 00000038 00002088 // auipc
2 0000003C 00000FFC // lui plus addi
2 00000040 000000E0 // jal link
2 00000044 000000EC // jalr link
2 00000FFC 00000005 // end marker

// ==== all.f ====
hw/rv_isa_pkg.sv
hw/rv_ctl_pkg.sv
hw/ctl_if.sv
hw/singlecycle_control.sv
hw/imm_decoder.sv
hw/regfile.sv
hw/rv_alu.sv
hw/singlecycle_datapath.sv
hw/rv_core.sv
tests/tb_clock.sv
tests/tb_core.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core
FILELIST  = all.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)
